//--- src.f
rtl/cw_pkg.sv
rtl/jtag_mux.sv
rtl/gpio_wb.sv
rtl/mask_cipher.sv
rtl/capture_core.sv
rtl/cw_board_top.sv
verification/tb_cw_board.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the capture target testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module tb_cw_board --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^No errors$" "$LOG_FILE"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- verification/tb_cw_board.sv
// Testbench for the capture target board top
// Drives the Wishbone port and a pad model and checks GPIO, cipher, trigger and JTAG overlay

`timescale 1ns/1ps

module tb_cw_board import cw_pkg::*; ();

  localparam int          BusTimeout  = 20;
  localparam int          PollTimeout = 50;
  localparam logic [31:0] LfsrTaps    = 32'h8020_0003;
  localparam pad_vec_t    TrigMask    = pad_vec_t'(1) << TriggerIdx;
  localparam pad_vec_t    StrapMask   = pad_vec_t'(1) << JtagEnIdx;

  logic        clk_main = 1'b0;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  pad_vec_t    pad_in = '0;
  pad_vec_t    pad_out;
  pad_vec_t    pad_oe;
  logic        jtag_tck;
  logic        jtag_tms;
  logic        jtag_tdi;
  logic        jtag_tdo;

  logic [31:0] lfsr_state = 32'd72228;
  pad_vec_t    pad_rand;
  pad_vec_t    exp_out;
  pad_vec_t    exp_oe;
  pad_vec_t    req_pad_out;

  always #4 clk_main = ~clk_main;

  cw_board_top i_cw_board_top (
    .clk_main_i (clk_main),
    .reset_i    (reset),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .pad_in_i   (pad_in),
    .pad_out_o  (pad_out),
    .pad_oe_o   (pad_oe),
    .jtag_tck_o (jtag_tck),
    .jtag_tms_o (jtag_tms),
    .jtag_tdi_o (jtag_tdi),
    .jtag_tdo_i (jtag_tdo)
  );

  // Driven pads loop back and the rest float to random levels
  always @(posedge clk_main) begin
    #1;
    pad_in <= (pad_oe & pad_out) | (~pad_oe & pad_rand);
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ LfsrTaps;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  // Eight rounds of rotate-left-3 of (data ^ key) plus round number
  function automatic logic [31:0] cipher_model(input logic [31:0] key, input logic [31:0] data);
    logic [31:0] d;
    logic [31:0] x;
    d = data;
    for (int r = 0; r < CipherRounds; r++) begin
      x = d ^ key;
      d = ((x << 3) | (x >> 29)) + 32'(r);
    end
    return d;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_main);
      #1;
    end
  endtask

  // One classic cycle followed by one idle cycle with stb low
  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    logic done;
    done  = 1'b0;
    rdata = '0;
    wb_req.cyc  = 1'b1;
    wb_req.stb  = 1'b1;
    wb_req.we   = we;
    wb_req.adr  = adr;
    wb_req.dat  = wdata;
    wb_req.sel  = 4'hf;
    req_pad_out = pad_out;
    for (int i = 0; i < BusTimeout && !done; i++) begin
      @(posedge clk_main);
      #1;
      if (wb_rsp.ack) begin
        rdata = wb_rsp.dat;
        done  = 1'b1;
      end
    end
    if (!done) begin
      abort_run($sformatf("Bus access to address %0d got no ack", adr));
    end
    wb_req = '0;
    wait_cycles(1);
  endtask

  task automatic bus_write(input logic [3:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic bus_read(input logic [3:0] adr, output logic [31:0] rdata);
    bus_access(1'b0, adr, '0, rdata);
  endtask

  // Start a run and poll busy while checking the trigger pad on every poll
  task automatic run_cipher(input logic [31:0] key, input logic [31:0] data,
                            output logic [31:0] result, output int busy_polls);
    logic [31:0] rdata;
    logic        busy;
    int          polls;
    bus_write(AdrKey, key);
    bus_write(AdrData, data);
    bus_write(AdrCtrl, 32'd1);
    busy       = 1'b1;
    polls      = 0;
    busy_polls = 0;
    while (busy) begin
      if (polls == PollTimeout) begin
        abort_run("Cipher still busy after the poll limit");
      end
      bus_read(AdrCtrl, rdata);
      busy = rdata[0];
      check_value("pad_out[15]", 32'(req_pad_out[TriggerIdx]),
                  32'(exp_out[TriggerIdx] & busy));
      if (busy) begin
        busy_polls++;
      end
      polls++;
    end
    bus_read(AdrResult, result);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_state();
    logic [31:0] rdata;
    check_value("ack", 32'(wb_rsp.ack), '0);
    check_value("pad_oe", 32'(pad_oe), '0);
    check_value("pad_out", 32'(pad_out), '0);
    bus_read(AdrGpioOut, rdata);
    check_value("GPIO_OUT", rdata, '0);
    bus_read(AdrGpioOe, rdata);
    check_value("GPIO_OE", rdata, '0);
    bus_read(AdrCtrl, rdata);
    check_value("CTRL", rdata, '0);
  endtask

  task automatic gpio_loopback();
    logic [31:0] rdata;
    pad_vec_t    exp_in;
    for (int n = 0; n < 4; n++) begin
      // Strap stays low here so JTAG never takes over
      pad_rand = pad_vec_t'(rand_bits(NumIos)) & ~StrapMask;
      exp_out  = pad_vec_t'(rand_bits(NumIos)) & ~StrapMask;
      exp_oe   = pad_vec_t'(rand_bits(NumIos));
      bus_write(AdrGpioOut, 32'(exp_out));
      bus_write(AdrGpioOe, 32'(exp_oe));
      bus_read(AdrGpioOut, rdata);
      check_value("GPIO_OUT", rdata, 32'(exp_out));
      bus_read(AdrGpioOe, rdata);
      check_value("GPIO_OE", rdata, 32'(exp_oe));
      check_value("pad_out", 32'(pad_out), 32'(exp_out & ~TrigMask));
      check_value("pad_oe", 32'(pad_oe), 32'(exp_oe));
      wait_cycles(3);
      exp_in = (exp_oe & exp_out & ~TrigMask) | (~exp_oe & pad_rand);
      bus_read(AdrGpioIn, rdata);
      check_value("GPIO_IN", rdata, 32'(exp_in));
    end
  endtask

  task automatic cipher_results();
    logic [31:0] key;
    logic [31:0] data;
    logic [31:0] result;
    int          busy_polls;
    for (int n = 0; n < 4; n++) begin
      key  = rand_bits(32);
      data = rand_bits(32);
      run_cipher(key, data, result, busy_polls);
      check_value("busy polls seen", 32'(busy_polls > 0), 32'd1);
      check_value("RESULT", result, cipher_model(key, data));
    end
  endtask

  task automatic trigger_gating();
    logic [31:0] result;
    logic [31:0] key;
    logic [31:0] data;
    int          busy_polls;
    exp_out = TrigMask;
    exp_oe  = TrigMask;
    bus_write(AdrGpioOut, 32'(exp_out));
    bus_write(AdrGpioOe, 32'(exp_oe));
    check_value("pad_out[15] idle", 32'(pad_out[TriggerIdx]), '0);
    key  = rand_bits(32);
    data = rand_bits(32);
    run_cipher(key, data, result, busy_polls);
    check_value("busy polls seen", 32'(busy_polls > 0), 32'd1);
    check_value("pad_out[15] done", 32'(pad_out[TriggerIdx]), '0);
    check_value("RESULT", result, cipher_model(key, data));
  endtask

  task automatic jtag_overlay();
    logic [31:0] rdata;
    logic [31:0] tdo_bits;
    exp_out = '0;
    exp_oe  = '0;
    bus_write(AdrGpioOut, '0);
    bus_write(AdrGpioOe, '0);
    for (int n = 0; n < 3; n++) begin
      pad_rand = pad_vec_t'(rand_bits(NumIos)) | StrapMask;
      tdo_bits = rand_bits(1);
      jtag_tdo = tdo_bits[0];
      wait_cycles(3);
      check_value("jtag_tck", 32'(jtag_tck), 32'(pad_rand[TckIdx]));
      check_value("jtag_tms", 32'(jtag_tms), 32'(pad_rand[TmsIdx]));
      check_value("jtag_tdi", 32'(jtag_tdi), 32'(pad_rand[TdiIdx]));
      check_value("pad_out[19]", 32'(pad_out[TdoIdx]), 32'(jtag_tdo));
      check_value("pad_oe", 32'(pad_oe), 32'(pad_vec_t'(1) << TdoIdx));
      // Core side reads TCK, TMS, TDI, TDO as 0, 1, 0, 0
      bus_read(AdrGpioIn, rdata);
      check_value("GPIO_IN", rdata, 32'({4'b0010, pad_rand[NumMio-1:0]}));
    end
    pad_rand = '0;
  endtask

  initial begin
    reset    = 1'b1;
    wb_req   = '0;
    jtag_tdo = 1'b0;
    pad_rand = '0;
    exp_out  = '0;
    exp_oe   = '0;
    repeat (10) @(posedge clk_main);
    #1;
    reset = 1'b0;
    wait_cycles(1);

    reset_state();
    gpio_loopback();
    cipher_results();
    trigger_gating();
    jtag_overlay();

    $display("No errors");
    $finish;
  end

endmodule : tb_cw_board

//--- rtl/cw_board_top.sv
// Board-level wrapper of the capture target
// Places the JTAG overlay between the core pad vectors and the board pads

`timescale 1ns/1ps

module cw_board_top import cw_pkg::*; #(
  parameter int Rounds  = CipherRounds,
  parameter int TrigIdx = TriggerIdx
) (
  input  logic     clk_main_i,
  input  logic     reset_i,
  input  wb_req_t  wb_req_i,
  output wb_rsp_t  wb_rsp_o,
  input  pad_vec_t pad_in_i,
  output pad_vec_t pad_out_o,
  output pad_vec_t pad_oe_o,
  output logic     jtag_tck_o,
  output logic     jtag_tms_o,
  output logic     jtag_tdi_o,
  input  logic     jtag_tdo_i
);

  pad_vec_t core_out;
  pad_vec_t core_oe;
  pad_vec_t core_in;

  jtag_mux #(
    .NumIos    (NumIos),
    .JtagEnIdx (JtagEnIdx),
    .TckIdx    (TckIdx),
    .TmsIdx    (TmsIdx),
    .TdiIdx    (TdiIdx),
    .TdoIdx    (TdoIdx),
    .TieOff    (JtagTieOff)
  ) i_jtag_mux (
    .core_out_i (core_out),
    .core_oe_i  (core_oe),
    .core_in_o  (core_in),
    .pad_out_o  (pad_out_o),
    .pad_oe_o   (pad_oe_o),
    .pad_in_i   (pad_in_i),
    .jtag_tck_o (jtag_tck_o),
    .jtag_tms_o (jtag_tms_o),
    .jtag_tdi_o (jtag_tdi_o),
    .jtag_tdo_i (jtag_tdo_i)
  );

  capture_core #(
    .TrigIdx (TrigIdx),
    .Rounds  (Rounds)
  ) i_capture_core (
    .clk_main_i (clk_main_i),
    .reset_i    (reset_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .core_out_o (core_out),
    .core_oe_o  (core_oe),
    .core_in_i  (core_in)
  );

endmodule : cw_board_top

//--- rtl/capture_core.sv
// Core of the capture target, GPIO and cipher behind one Wishbone port
// Also gates the scope trigger pad with the cipher busy flag

`timescale 1ns/1ps

module capture_core import cw_pkg::*; #(
  parameter int TrigIdx = TriggerIdx,
  parameter int Rounds  = CipherRounds
) (
  input  logic     clk_main_i,
  input  logic     reset_i,
  input  wb_req_t  wb_req_i,
  output wb_rsp_t  wb_rsp_o,
  output pad_vec_t core_out_o,
  output pad_vec_t core_oe_o,
  input  pad_vec_t core_in_i
);

  wb_req_t  gpio_req;
  wb_req_t  ciph_req;
  wb_rsp_t  gpio_rsp;
  wb_rsp_t  ciph_rsp;
  pad_vec_t gpio_out;
  logic     ciph_busy;
  logic     gpio_sel;
  logic     ciph_sel;
  logic     none_sel;
  logic     none_ack_q;

  ////////////////////////////////
  // Address decode
  ////////////////////////////////

  // 0-3 GPIO, 4-7 cipher, upper half unmapped
  assign gpio_sel = ~wb_req_i.adr[3] & ~wb_req_i.adr[2];
  assign ciph_sel = ~wb_req_i.adr[3] &  wb_req_i.adr[2];
  assign none_sel =  wb_req_i.adr[3];

  always_comb begin
    gpio_req     = wb_req_i;
    ciph_req     = wb_req_i;
    gpio_req.stb = wb_req_i.stb & gpio_sel;
    ciph_req.stb = wb_req_i.stb & ciph_sel;
  end

  // Unmapped accesses still complete, reading zero
  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= wb_req_i.cyc & wb_req_i.stb & none_sel & ~none_ack_q;
    end
  end

  assign wb_rsp_o.ack = gpio_rsp.ack | ciph_rsp.ack | none_ack_q;
  assign wb_rsp_o.dat = gpio_rsp.ack ? gpio_rsp.dat :
                        ciph_rsp.ack ? ciph_rsp.dat : '0;

  gpio_wb i_gpio_wb (
    .clk_main_i (clk_main_i),
    .reset_i    (reset_i),
    .wb_req_i   (gpio_req),
    .wb_rsp_o   (gpio_rsp),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (core_oe_o),
    .gpio_in_i  (core_in_i)
  );

  mask_cipher #(
    .Rounds (Rounds)
  ) i_mask_cipher (
    .clk_main_i (clk_main_i),
    .reset_i    (reset_i),
    .wb_req_i   (ciph_req),
    .wb_rsp_o   (ciph_rsp),
    .busy_o     (ciph_busy)
  );

  // Trigger only fires while the cipher is actually running
  always_comb begin
    core_out_o          = gpio_out;
    core_out_o[TrigIdx] = gpio_out[TrigIdx] & ciph_busy;
  end

endmodule : capture_core

//--- rtl/mask_cipher.sv
// Iterative cipher on the Wishbone bus, one round per clock
// Write key and data, write 1 to CTRL, poll CTRL until busy clears, read RESULT

`timescale 1ns/1ps

module mask_cipher import cw_pkg::*; #(
  parameter int Rounds = CipherRounds
) (
  input  logic    clk_main_i,
  input  logic    reset_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output logic    busy_o
);

  localparam int RndW = $clog2(Rounds);

  logic [31:0]     key_q;
  logic [31:0]     data_q;
  logic [31:0]     state_q;
  logic [31:0]     result_q;
  logic [31:0]     rdata_q;
  logic [31:0]     round_next;
  logic [RndW-1:0] round_q;
  logic            busy_q;
  logic            ack_q;
  logic            access;
  logic            wr_en;
  logic            start;
  logic            last_round;

  // data ^ key, rotate left by 3, add the round number
  function automatic logic [31:0] cipher_round(logic [31:0] d, logic [31:0] k,
                                               logic [31:0] r);
    logic [31:0] x;
    x = d ^ k;
    return {x[28:0], x[31:29]} + r;
  endfunction

  assign access     = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_en      = access & wb_req_i.we;
  assign start      = wr_en & (wb_req_i.adr[1:0] == AdrCtrl[1:0]) & wb_req_i.dat[0] & ~busy_q;
  assign last_round = (round_q == RndW'(Rounds - 1));
  assign round_next = cipher_round(state_q, key_q, 32'(round_q));

  ////////////////////////////////
  // Control
  ////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      busy_q  <= 1'b0;
      round_q <= '0;
    end else begin
      ack_q <= access;
      if (start) begin
        busy_q  <= 1'b1;
        round_q <= '0;
      end else if (busy_q) begin
        round_q <= round_q + RndW'(1);
        if (last_round) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////
  // Datapath
  ////////////////////////////////

  // Key and data are held while a run is in progress
  always_ff @(posedge clk_main_i) begin
    if (wr_en && !busy_q) begin
      case (wb_req_i.adr[1:0])
        AdrKey[1:0]:  key_q  <= wb_req_i.dat;
        AdrData[1:0]: data_q <= wb_req_i.dat;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (start) begin
      state_q <= data_q;
    end else if (busy_q) begin
      state_q <= round_next;
    end
    if (busy_q && last_round) begin
      result_q <= round_next;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (access) begin
      case (wb_req_i.adr[1:0])
        AdrKey[1:0]:    rdata_q <= key_q;
        AdrData[1:0]:   rdata_q <= data_q;
        AdrCtrl[1:0]:   rdata_q <= {31'b0, busy_q};
        AdrResult[1:0]: rdata_q <= result_q;
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign busy_o       = busy_q;

endmodule : mask_cipher

//--- rtl/gpio_wb.sv
// GPIO slave on the Wishbone bus
// Output and enable registers per pad, plus synchronized pad inputs for reads

`timescale 1ns/1ps

module gpio_wb import cw_pkg::*; (
  input  logic     clk_main_i,
  input  logic     reset_i,
  input  wb_req_t  wb_req_i,
  output wb_rsp_t  wb_rsp_o,
  output pad_vec_t gpio_out_o,
  output pad_vec_t gpio_oe_o,
  input  pad_vec_t gpio_in_i
);

  pad_vec_t    out_q;
  pad_vec_t    oe_q;
  pad_vec_t    in_meta_q;
  pad_vec_t    in_sync_q;
  logic        ack_q;
  logic [31:0] rdata_q;
  logic        access;

  // New request, the cycle before its ack
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  ////////////////////////////////
  // Registers
  ////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (access && wb_req_i.we) begin
      case (wb_req_i.adr[1:0])
        AdrGpioOut[1:0]: out_q <= wb_req_i.dat[NumIos-1:0];
        AdrGpioOe[1:0]:  oe_q  <= wb_req_i.dat[NumIos-1:0];
        default: ;
      endcase
    end
  end

  // Two-flop synchronizer on the pad inputs
  always_ff @(posedge clk_main_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // Read data lands together with ack
  always_ff @(posedge clk_main_i) begin
    if (access) begin
      case (wb_req_i.adr[1:0])
        AdrGpioOut[1:0]: rdata_q <= 32'(out_q);
        AdrGpioOe[1:0]:  rdata_q <= 32'(oe_q);
        AdrGpioIn[1:0]:  rdata_q <= 32'(in_sync_q);
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign gpio_out_o   = out_q;
  assign gpio_oe_o    = oe_q;

endmodule : gpio_wb

//--- rtl/jtag_mux.sv
// JTAG overlay between the core pad vectors and the padring
// A strap pad hands the four JTAG pads to the TAP and feeds tie-offs to the core

`timescale 1ns/1ps

module jtag_mux #(
  parameter int                NumIos    = 20,
  parameter int                JtagEnIdx = 12,
  parameter int                TckIdx    = 16,
  parameter int                TmsIdx    = 17,
  parameter int                TdiIdx    = 18,
  parameter int                TdoIdx    = 19,
  parameter logic [NumIos-1:0] TieOff    = '0
) (
  // Core side
  input  logic [NumIos-1:0] core_out_i,
  input  logic [NumIos-1:0] core_oe_i,
  output logic [NumIos-1:0] core_in_o,
  // Padring side
  output logic [NumIos-1:0] pad_out_o,
  output logic [NumIos-1:0] pad_oe_o,
  input  logic [NumIos-1:0] pad_in_i,
  // TAP side
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  input  logic              jtag_tdo_i
);

  logic jtag_en;

  // Strap is sampled straight from the pad, active high
  assign jtag_en = pad_in_i[JtagEnIdx];

  always_comb begin
    pad_out_o  = core_out_i;
    pad_oe_o   = core_oe_i;
    core_in_o  = pad_in_i;
    jtag_tck_o = 1'b0;
    jtag_tms_o = 1'b0;
    jtag_tdi_o = 1'b0;

    if (jtag_en) begin
      // TAP inputs, pads left undriven
      jtag_tck_o = pad_in_i[TckIdx];
      jtag_tms_o = pad_in_i[TmsIdx];
      jtag_tdi_o = pad_in_i[TdiIdx];
      pad_out_o[TckIdx] = 1'b0;
      pad_out_o[TmsIdx] = 1'b0;
      pad_out_o[TdiIdx] = 1'b0;
      pad_oe_o[TckIdx]  = 1'b0;
      pad_oe_o[TmsIdx]  = 1'b0;
      pad_oe_o[TdiIdx]  = 1'b0;

      // TDO always driven while the TAP owns the pad
      pad_out_o[TdoIdx] = jtag_tdo_i;
      pad_oe_o[TdoIdx]  = 1'b1;

      // Core sees quiet values on the borrowed pads
      core_in_o[TckIdx] = TieOff[TckIdx];
      core_in_o[TmsIdx] = TieOff[TmsIdx];
      core_in_o[TdiIdx] = TieOff[TdiIdx];
      core_in_o[TdoIdx] = TieOff[TdoIdx];
    end
  end

endmodule : jtag_mux

//--- rtl/cw_pkg.sv
// Shared constants and types for the capture target
// Pad layout, JTAG overlay indices, register map, cipher constants and bus structs

package cw_pkg;

  // Pad counts, MIO first then DIO
  localparam int NumMio = 16;
  localparam int NumDio = 4;
  localparam int NumIos = NumMio + NumDio;

  typedef logic [NumIos-1:0] pad_vec_t;

  // JTAG overlay pads
  localparam int JtagEnIdx = 12;
  localparam int TckIdx    = NumMio + 0;
  localparam int TmsIdx    = NumMio + 1;
  localparam int TdiIdx    = NumMio + 2;
  localparam int TdoIdx    = NumMio + 3;

  // Scope trigger on GPIO 15
  localparam int TriggerIdx = 15;

  // Core-side inputs while JTAG owns the DIO pads, TMS idles high
  localparam pad_vec_t JtagTieOff = pad_vec_t'(1) << TmsIdx;

  // Word address map
  localparam logic [3:0] AdrGpioOut = 4'd0;
  localparam logic [3:0] AdrGpioOe  = 4'd1;
  localparam logic [3:0] AdrGpioIn  = 4'd2;
  localparam logic [3:0] AdrKey     = 4'd4;
  localparam logic [3:0] AdrData    = 4'd5;
  localparam logic [3:0] AdrCtrl    = 4'd6;
  localparam logic [3:0] AdrResult  = 4'd7;

  localparam int CipherRounds = 8;

  // Wishbone classic, word addressed
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage
